// ==== design/mpmc_ack_route.sv ====
`default_nettype none

// Acknowledge router
// Turns the completion pulse into the ack of the granted port and hands
// that port its read data; every other port keeps its last read word

module mpmc_ack_route #(
	parameter int NUM_PORTS = mpmc_pkg::NUM_PORTS
) (
	input wire clk,
	input wire rst_n,
	input wire done,
	input wire mpmc_pkg::ch_t ch,
	input wire mpmc_pkg::data_t mem_q,
	output logic wb_ack [NUM_PORTS],
	output mpmc_pkg::data_t wb_dat_r [NUM_PORTS]
);

	// One-cycle ack, only the port that ch points at can see it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				wb_ack[p] <= 1'b0;
			end
		end else begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				wb_ack[p] <= done && (int'(ch) == p);
			end
		end
	end

	// Read data register per port, loaded alongside its ack
	always_ff @(posedge clk) begin
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (done && int'(ch) == p) begin
				wb_dat_r[p] <= mem_q;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/mpmc_ch_arbiter.sv ====
`default_nettype none

// Round-robin arbiter over the Wishbone ports
// A port requests when both cyc and stb are high
// Only one request is ever in flight, so a grant is issued in IDLE only

module mpmc_ch_arbiter #(
	parameter int NUM_PORTS = mpmc_pkg::NUM_PORTS
) (
	input wire clk,
	input wire rst_n,
	input wire wb_cyc [NUM_PORTS],
	input wire wb_stb [NUM_PORTS],
	input wire mpmc_pkg::seq_state_t state,
	output mpmc_pkg::ch_t ch,
	output logic grant
);

	// Winner of the current scan and whether anyone requested at all
	mpmc_pkg::ch_t next_ch;
	logic next_valid;

	// Scan starts at the port after the last granted one and wraps around
	// The last granted port is scanned last, so a busy port cannot starve others
	always_comb begin
		int idx;
		next_ch = ch;
		next_valid = 1'b0;
		for (int i = 1; i <= NUM_PORTS; i++) begin
			idx = (int'(ch) + i) % NUM_PORTS;
			if (!next_valid && wb_cyc[idx] && wb_stb[idx]) begin
				next_ch = mpmc_pkg::ch_t'(idx);
				next_valid = 1'b1;
			end
		end
	end

	// ==================================================
	// Grant register
	// ==================================================

	// ch doubles as the round-robin pointer
	// It resets to the highest port so port 0 is first in line
	// grant is a single-cycle pulse; the !grant term stops a second pulse
	// in the cycle before the sequencer leaves IDLE
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ch <= mpmc_pkg::ch_t'(NUM_PORTS - 1);
			grant <= 1'b0;
		end else begin
			grant <= 1'b0;
			if (state == mpmc_pkg::IDLE && !grant && next_valid) begin
				ch <= next_ch;
				grant <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/mpmc_mem.sv ====
`default_nettype none

// Shared single-port word memory
// Read data is registered, giving one cycle of latency
// A write returns the previous content of the addressed word

module mpmc_mem #(
	parameter int ADDR_W = mpmc_pkg::ADDR_W,
	parameter int DATA_W = mpmc_pkg::DATA_W
) (
	input wire clk,
	input wire mem_en,
	input wire req_we,
	input wire mpmc_pkg::addr_t req_adr,
	input wire mpmc_pkg::data_t req_dat,
	output mpmc_pkg::data_t mem_q
);

	// Storage array, contents are undefined until written
	logic [DATA_W-1:0] mem_array [2**ADDR_W];

	// Read-before-write on the same port
	always_ff @(posedge clk) begin
		if (mem_en) begin
			if (req_we) begin
				mem_array[req_adr] <= req_dat;
			end
			mem_q <= mem_array[req_adr];
		end
	end

endmodule

`default_nettype wire

// ==== design/mpmc_pkg.sv ====
`default_nettype none

// ==================================================
// Shared widths, types and defaults
// ==================================================

package mpmc_pkg;

	// Default word address width in bits
	parameter int ADDR_W = 8;

	// Default data word width in bits
	parameter int DATA_W = 32;

	// Default number of Wishbone slave ports
	parameter int NUM_PORTS = 4;

	// Width of a port index, derived from the port count
	parameter int CH_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

	// A word address into the shared memory
	typedef logic [ADDR_W-1:0] addr_t;

	// One data word as seen on the Wishbone data buses
	typedef logic [DATA_W-1:0] data_t;

	// Index of a Wishbone port
	typedef logic [CH_W-1:0] ch_t;

	// ==================================================
	// Sequencer states
	// ==================================================

	// IDLE waits for a grant and lets the capture stage follow the arbiter
	// ACCESS enables the memory for exactly one cycle
	// MEM_WAIT covers the read latency of the memory
	// DONE signals completion to the acknowledge router
	// RECOVER gives the master a cycle to drop its strobe
	typedef enum logic [2:0] {
		IDLE     = 3'd0,
		ACCESS   = 3'd1,
		MEM_WAIT = 3'd2,
		DONE     = 3'd3,
		RECOVER  = 3'd4
	} seq_state_t;

endpackage

`default_nettype wire

// ==== design/mpmc_req_capture.sv ====
`default_nettype none

// Request capture stage
// While the sequencer idles, the fields of the port selected by ch are
// copied every cycle, so the cycle after the grant holds the granted request
// Once the sequencer leaves IDLE the fields freeze for the whole access

module mpmc_req_capture #(
	parameter int NUM_PORTS = mpmc_pkg::NUM_PORTS
) (
	input wire clk,
	input wire rst_n,
	input wire mpmc_pkg::seq_state_t state,
	input wire mpmc_pkg::ch_t ch,
	input wire wb_we [NUM_PORTS],
	input wire mpmc_pkg::addr_t wb_adr [NUM_PORTS],
	input wire mpmc_pkg::data_t wb_dat_w [NUM_PORTS],
	output logic req_we,
	output mpmc_pkg::addr_t req_adr,
	output mpmc_pkg::data_t req_dat
);

	// ==================================================
	// Write flag
	// ==================================================

	// The write flag follows the port that ch points at while idle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_we <= 1'b0;
		end else if (state == mpmc_pkg::IDLE) begin
			req_we <= wb_we[ch];
		end
	end

	// ==================================================
	// Address and write data
	// ==================================================

	// Payload registers follow the same enable as the write flag
	// Their value only matters once req_we and mem_en qualify them
	always_ff @(posedge clk) begin
		if (state == mpmc_pkg::IDLE) begin
			req_adr <= wb_adr[ch];
			req_dat <= wb_dat_w[ch];
		end
	end

endmodule

`default_nettype wire

// ==== design/mpmc_seq.sv ====
`default_nettype none

// Access sequencer
// Walks one request through the shared memory and reports completion
// The path is fixed, so every access takes the same number of cycles

module mpmc_seq (
	input wire clk,
	input wire rst_n,
	input wire grant,
	output mpmc_pkg::seq_state_t state,
	output logic mem_en,
	output logic done
);

	mpmc_pkg::seq_state_t next_state;

	// ==================================================
	// Next state
	// ==================================================

	always_comb begin
		next_state = state;
		case (state)
			mpmc_pkg::IDLE: begin
				// The grant pulse arrives one cycle after the arbiter sees the
				// request, and the capture stage has the fields by then
				if (grant) begin
					next_state = mpmc_pkg::ACCESS;
				end
			end
			mpmc_pkg::ACCESS: begin
				next_state = mpmc_pkg::MEM_WAIT;
			end
			mpmc_pkg::MEM_WAIT: begin
				// Memory output register is loaded at the end of ACCESS
				next_state = mpmc_pkg::DONE;
			end
			mpmc_pkg::DONE: begin
				next_state = mpmc_pkg::RECOVER;
			end
			mpmc_pkg::RECOVER: begin
				// The master sees ack here and drops stb, so the arbiter
				// finds the old request gone when IDLE comes back
				next_state = mpmc_pkg::IDLE;
			end
			default: begin
				next_state = mpmc_pkg::IDLE;
			end
		endcase
	end

	// State register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= mpmc_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

	// ==================================================
	// Outputs
	// ==================================================

	// Memory enable is high for the single ACCESS cycle
	assign mem_en = (state == mpmc_pkg::ACCESS);

	// Completion pulse while in DONE, the router registers it
	assign done = (state == mpmc_pkg::DONE);

endmodule

`default_nettype wire

// ==== design/mpmc_top.sv ====
`default_nettype none

// Multi-port memory controller top level
// NUM_PORTS Wishbone classic slaves share one synchronous memory
// Requests go arbiter, capture, sequencer with memory, router in turn

module mpmc_top #(
	parameter int NUM_PORTS = mpmc_pkg::NUM_PORTS,
	parameter int ADDR_W = mpmc_pkg::ADDR_W,
	parameter int DATA_W = mpmc_pkg::DATA_W
) (
	input wire clk,
	input wire rst_n,
	input wire wb_cyc [NUM_PORTS],
	input wire wb_stb [NUM_PORTS],
	input wire wb_we [NUM_PORTS],
	input wire mpmc_pkg::addr_t wb_adr [NUM_PORTS],
	input wire mpmc_pkg::data_t wb_dat_w [NUM_PORTS],
	output logic wb_ack [NUM_PORTS],
	output mpmc_pkg::data_t wb_dat_r [NUM_PORTS]
);

	// ==================================================
	// Stage to stage signals
	// ==================================================

	mpmc_pkg::seq_state_t state;
	mpmc_pkg::ch_t ch;
	logic grant;
	logic req_we;
	mpmc_pkg::addr_t req_adr;
	mpmc_pkg::data_t req_dat;
	logic mem_en;
	logic done;
	mpmc_pkg::data_t mem_q;

	// Picks the next requesting port while the sequencer idles
	mpmc_ch_arbiter #(.NUM_PORTS(NUM_PORTS)) mpmc_ch_arbiter_i (
		.clk(clk), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb),
		.state(state), .ch(ch), .grant(grant)
	);

	// Freezes the granted port's request for the access
	mpmc_req_capture #(.NUM_PORTS(NUM_PORTS)) mpmc_req_capture_i (
		.clk(clk), .rst_n(rst_n), .state(state), .ch(ch),
		.wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
		.req_we(req_we), .req_adr(req_adr), .req_dat(req_dat)
	);

	// Fixed-length access sequence
	mpmc_seq mpmc_seq_i (
		.clk(clk), .rst_n(rst_n), .grant(grant),
		.state(state), .mem_en(mem_en), .done(done)
	);

	// Shared memory
	mpmc_mem #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) mpmc_mem_i (
		.clk(clk), .mem_en(mem_en), .req_we(req_we),
		.req_adr(req_adr), .req_dat(req_dat), .mem_q(mem_q)
	);

	// Ack and read data back to the granted port
	mpmc_ack_route #(.NUM_PORTS(NUM_PORTS)) mpmc_ack_route_i (
		.clk(clk), .rst_n(rst_n), .done(done), .ch(ch), .mem_q(mem_q),
		.wb_ack(wb_ack), .wb_dat_r(wb_dat_r)
	);

endmodule

`default_nettype wire

// ==== mpmc.f ====
design/mpmc_pkg.sv
design/mpmc_ch_arbiter.sv
design/mpmc_req_capture.sv
design/mpmc_seq.sv
design/mpmc_mem.sv
design/mpmc_ack_route.sv
design/mpmc_top.sv
tb/mpmc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module mpmc_tb -f mpmc.f -o mpmc_sim \
	&& ./obj_dir/mpmc_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
	&& echo "mpmc simulation passed" \
	|| { echo "mpmc simulation failed"; exit 1; }

// ==== tb/mpmc_tb.sv ====
`default_nettype none

module mpmc_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_PORTS = mpmc_pkg::NUM_PORTS;
	localparam int ADDR_W = mpmc_pkg::ADDR_W;
	localparam int DATA_W = mpmc_pkg::DATA_W;
	// Longest gap allowed between two acks of one group
	localparam int ACK_TIMEOUT = 50;
	// Edges from stb rising to ack seen high for a port that is served first
	localparam int SOLO_LATENCY = 6;

	logic clk;
	logic rst_n;
	logic wb_cyc [NUM_PORTS];
	logic wb_stb [NUM_PORTS];
	logic wb_we [NUM_PORTS];
	mpmc_pkg::addr_t wb_adr [NUM_PORTS];
	mpmc_pkg::data_t wb_dat_w [NUM_PORTS];
	logic wb_ack [NUM_PORTS];
	mpmc_pkg::data_t wb_dat_r [NUM_PORTS];

	// Stimulus table with one entry per row in each queue
	int row_port [$];
	logic row_we [$];
	mpmc_pkg::addr_t row_adr [$];
	mpmc_pkg::data_t row_dat [$];
	int row_grp [$];

	// Reference memory updated in the order the acks arrive
	mpmc_pkg::data_t model_mem [2**ADDR_W];
	// Last served port
	// It starts at the highest port so port 0 goes first
	int rr_last;
	// Read word each port must keep showing until its next ack
	mpmc_pkg::data_t rd_held [NUM_PORTS];
	logic rd_known [NUM_PORTS];

	mpmc_top #(.NUM_PORTS(NUM_PORTS), .ADDR_W(ADDR_W), .DATA_W(DATA_W)) mpmc_top_i (
		.clk(clk), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
		.wb_ack(wb_ack), .wb_dat_r(wb_dat_r)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	// Compares one value with its expectation and stops at the first mismatch
	task automatic check_value(string what, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] time %0t: %s, got %h, expected %h", $time, what, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	// Appends a row whose data column comes from the seeded generator
	function automatic void add_row(int port, logic we, int adr, int grp);
		row_port.push_back(port);
		row_we.push_back(we);
		row_adr.push_back(mpmc_pkg::addr_t'(adr));
		row_dat.push_back(mpmc_pkg::data_t'($urandom));
		row_grp.push_back(grp);
	endfunction

	// ==================================================
	// Stimulus table
	// ==================================================

	function automatic void build_table();
		// All four ports at once right after reset are served in order 0 to 3
		add_row(0, 1'b1, 'h10, 0);
		add_row(1, 1'b1, 'h11, 0);
		add_row(2, 1'b1, 'h12, 0);
		add_row(3, 1'b1, 'h13, 0);
		// Issued once port 3 has been served, so port 0 comes before port 2
		add_row(2, 1'b0, 'h10, 1);
		add_row(0, 1'b0, 'h13, 1);
		// Every port writes a word and reads it back on its own
		for (int p = 0; p < NUM_PORTS; p++) begin
			add_row(p, 1'b1, 'h20 + p, 2 + 2 * p);
			add_row(p, 1'b0, 'h20 + p, 3 + 2 * p);
		end
		// Port 3 reads the word port 1 left in the shared memory
		add_row(1, 1'b1, 'h40, 10);
		add_row(3, 1'b0, 'h40, 11);
		// Address 0x50 is rewritten with other writes around it
		// The read must see the second value
		add_row(2, 1'b1, 'h50, 12);
		add_row(0, 1'b1, 'h51, 13);
		add_row(1, 1'b1, 'h52, 13);
		add_row(2, 1'b1, 'h50, 14);
		add_row(3, 1'b1, 'h53, 15);
		add_row(0, 1'b1, 'h54, 15);
		add_row(1, 1'b0, 'h50, 16);
		add_row(3, 1'b0, 'h50, 17);
		add_row(2, 1'b0, 'h51, 17);
	endfunction

	// Watches all acks for a number of cycles and expects none
	task automatic expect_no_ack(int cycles);
		for (int c = 0; c < cycles; c++) begin
			@(posedge clk);
			for (int p = 0; p < NUM_PORTS; p++) begin
				check_value($sformatf("ack on idle port %0d", p), int'(wb_ack[p]), 0);
			end
		end
	endtask

	// ==================================================
	// Wishbone masters for one group of rows
	// ==================================================

	task automatic run_group(int first, int last);
		int pending [NUM_PORTS];
		int order [$];
		int served;
		int cycles;
		int quiet;
		int want;
		int r;
		for (int q = 0; q < NUM_PORTS; q++) begin
			pending[q] = -1;
		end
		// All rows of the group raise cyc and stb on the same edge
		@(posedge clk);
		for (int i = first; i <= last; i++) begin
			pending[row_port[i]] = i;
			wb_cyc[row_port[i]] <= 1'b1;
			wb_stb[row_port[i]] <= 1'b1;
			wb_we[row_port[i]] <= row_we[i];
			wb_adr[row_port[i]] <= row_adr[i];
			wb_dat_w[row_port[i]] <= row_dat[i];
		end
		// Round-robin order starts at the port after the last served one
		for (int k = 1; k <= NUM_PORTS; k++) begin
			want = (rr_last + k) % NUM_PORTS;
			if (pending[want] >= 0) begin
				order.push_back(want);
			end
		end
		served = 0;
		cycles = 0;
		quiet = 0;
		while (served < order.size()) begin
			@(posedge clk);
			cycles++;
			quiet++;
			if (quiet > ACK_TIMEOUT) begin
				$display("Timeout: no ack within %0d cycles for group %0d",
					ACK_TIMEOUT, row_grp[first]);
				$display("SOME TESTS FAILED");
				$fatal(1);
			end
			for (int q = 0; q < NUM_PORTS; q++) begin
				if (wb_ack[q]) begin
					check_value($sformatf("ack on port %0d without a request", q),
						int'(pending[q] >= 0), 1);
					check_value("port order of acks", q, order[served]);
					if (served == 0) begin
						check_value("latency of the first served port", cycles, SOLO_LATENCY);
					end
					r = pending[q];
					if (row_we[r]) begin
						model_mem[row_adr[r]] = row_dat[r];
						rd_known[q] = 1'b0;
					end else begin
						check_value($sformatf("read data of port %0d at %h", q, row_adr[r]),
							wb_dat_r[q], model_mem[row_adr[r]]);
						rd_held[q] = model_mem[row_adr[r]];
						rd_known[q] = 1'b1;
					end
					// The master drops its request on the edge that shows ack
					wb_cyc[q] <= 1'b0;
					wb_stb[q] <= 1'b0;
					wb_we[q] <= 1'b0;
					pending[q] = -1;
					rr_last = q;
					served++;
					quiet = 0;
				end else if (rd_known[q]) begin
					// A port without ack keeps its last read word
					check_value($sformatf("held read data of port %0d", q),
						wb_dat_r[q], rd_held[q]);
				end
			end
		end
	endtask

	initial begin
		int first;
		int last;
		void'($urandom(32'h5831_2f27));
		rst_n = 1'b0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			wb_cyc[p] = 1'b0;
			wb_stb[p] = 1'b0;
			wb_we[p] = 1'b0;
			wb_adr[p] = '0;
			wb_dat_w[p] = '0;
			rd_known[p] = 1'b0;
		end
		rr_last = NUM_PORTS - 1;
		build_table();
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		// Nothing may answer before a request exists
		expect_no_ack(5);
		first = 0;
		while (first < row_port.size()) begin
			last = first;
			while (last + 1 < row_port.size() && row_grp[last + 1] == row_grp[first]) begin
				last++;
			end
			run_group(first, last);
			first = last + 1;
		end
		expect_no_ack(4);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
